/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_exu_top
FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR, TOP, FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* sim/tb_exu_top.sv */
module tb_exu_top;

  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_JALR = 7'b1100111;

  logic        clock;
  logic        reset;
  logic        in_valid = 1'b0;
  logic        in_ready;
  logic [31:0] in_pc = 32'd0;
  logic [31:0] in_inst = 32'h13;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        mem_req_valid;
  logic        mem_req_ready = 1'b1;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_resp_valid = 1'b0;
  logic [31:0] mem_rdata = 32'd0;
  logic        wb_valid;
  logic        wb_ready = 1'b1;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  int          seed = 21548;
  logic [31:0] rnd;
  int          errors = 0;
  int          cycle_count = 0;
  int          budget = 100;
  logic        running = 1'b0;
  logic        stall_mode = 1'b0;
  logic [31:0] fetch_pc = 32'd0;
  logic [31:0] prog [64];
  int          prog_len = 0;
  logic [31:0] dmem [64];
  logic        load_pend = 1'b0;
  int          load_wait = 0;
  logic [5:0]  load_idx = 6'd0;
  logic [4:0]  exp_rd [64];
  logic [31:0] exp_val [64];
  int          exp_n = 0;
  logic [4:0]  got_rd [64];
  logic [31:0] got_val [64];
  int          got_n = 0;

  exu_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // fetch model restarts at the redirect target
  always @(posedge clock) begin
    if (reset) begin
      fetch_pc <= 32'd0;
    end else if (redirect_valid) begin
      fetch_pc <= redirect_pc;
    end else if (in_valid && in_ready) begin
      fetch_pc <= fetch_pc + 32'd4;
    end
  end

  // memory model with one outstanding load
  always @(posedge clock) begin
    if (reset) begin
      load_pend = 1'b0;
    end else begin
      if (load_pend) begin
        load_wait = load_wait - 1;
        if (load_wait == 0) begin
          load_pend = 1'b0;
        end
      end
      if (mem_req_valid && mem_req_ready) begin
        if (mem_write) begin
          dmem[mem_addr[7:2]] = mem_wdata;
        end else begin
          load_pend = 1'b1;
          load_idx = mem_addr[7:2];
          load_wait = 1 + ($random(seed) & 3);
        end
      end
    end
  end

  always @(posedge clock) begin
    if (!reset && wb_valid && wb_ready && got_n < 64) begin
      got_rd[got_n] = wb_rd;
      got_val[got_n] = wb_data;
      got_n = got_n + 1;
    end
  end

  always @(negedge clock) begin
    rnd = $random(seed);
    in_valid = running && (fetch_pc[31:2] < prog_len);
    in_pc = fetch_pc;
    in_inst = prog[fetch_pc[7:2]];
    wb_ready = !stall_mode || rnd[0];
    mem_req_ready = !stall_mode || rnd[1];
    mem_resp_valid = load_pend && (load_wait == 1);
    mem_rdata = dmem[load_idx];
  end

  initial begin
    while (cycle_count <= budget) begin
      @(posedge clock);
      cycle_count = cycle_count + 1;
    end
    $display("watchdog expired after %0d cycles, the DUT stopped committing", cycle_count);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'h5EED0000 + idx * 32'h00010003;
  endfunction

  task automatic clear_program();
    prog_len = 0;
    exp_n = 0;
    for (int i = 0; i < 64; i++) begin
      prog[i] = 32'h13;
    end
  endtask

  task automatic put(input logic [31:0] inst);
    prog[prog_len] = inst;
    prog_len = prog_len + 1;
  endtask

  task automatic expect_commit(input logic [4:0] rd, input logic [31:0] val);
    exp_rd[exp_n] = rd;
    exp_val[exp_n] = val;
    exp_n = exp_n + 1;
  endtask

  task automatic check_value(input string name, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %h actual %h", name, what, exp, act);
      errors = errors + 1;
    end
  endtask

  // reset, check the idle outputs, then let the fetch model go
  task automatic start_run(input string name, input logic stall);
    @(posedge clock);
    running = 1'b0;
    stall_mode = stall;
    budget = budget + 200 * prog_len;
    @(negedge clock);
    reset = 1'b1;
    repeat (2) @(posedge clock);
    running = 1'b1;
    got_n = 0;
    @(negedge clock);
    check_value(name, "in_ready after reset", 32'd1, 32'(in_ready));
    check_value(name, "wb_valid after reset", 32'd0, 32'(wb_valid));
    check_value(name, "mem_req_valid after reset", 32'd0, 32'(mem_req_valid));
    check_value(name, "redirect_valid after reset", 32'd0, 32'(redirect_valid));
    reset = 1'b0;
  endtask

  task automatic run_program(input string name, input logic stall);
    start_run(name, stall);
    while (got_n < exp_n) @(negedge clock);
    // a quiet tail catches extra commits
    repeat (20) @(posedge clock);
    running = 1'b0;
    for (int i = 0; i < exp_n; i++) begin
      if (i >= got_n) begin
        $display("%s: commit %0d never arrived", name, i);
        errors = errors + 1;
      end else begin
        check_value(name, $sformatf("commit %0d rd", i), 32'(exp_rd[i]), 32'(got_rd[i]));
        check_value(name, $sformatf("commit %0d data", i), exp_val[i], got_val[i]);
      end
    end
    if (got_n > exp_n) begin
      $display("%s: %0d commits seen where %0d were expected", name, got_n, exp_n);
      errors = errors + 1;
    end
  endtask

  task automatic load_alu_program();
    clear_program();
    put(u_type(OP_LUI, 1, 20'h12345));
    expect_commit(1, 32'h12345000);
    put(i_type(3'd0, 2, 1, 12'h678, OP_IMM));
    expect_commit(2, 32'h12345678);
    put(u_type(OP_AUIPC, 3, 20'h00001));
    expect_commit(3, 32'h8 + 32'h1000);
    put(r_type(7'h20, 3'd0, 4, 2, 3));
    expect_commit(4, 32'h12345678 - 32'h1008);
    put(i_type(3'd0, 5, 0, 12'hFFB, OP_IMM));
    expect_commit(5, 32'hFFFFFFFB);
    put(i_type(3'd5, 6, 5, 12'h401, OP_IMM));
    expect_commit(6, 32'hFFFFFFFD);
    put(i_type(3'd5, 7, 5, 12'h01C, OP_IMM));
    expect_commit(7, 32'h0000000F);
    put(r_type(7'h00, 3'd2, 8, 5, 7));
    expect_commit(8, 32'd1);
    put(r_type(7'h00, 3'd3, 9, 5, 7));
    expect_commit(9, 32'd0);
    put(i_type(3'd4, 10, 2, 12'h0FF, OP_IMM));
    expect_commit(10, 32'h12345687);
    put(r_type(7'h00, 3'd6, 11, 7, 3));
    expect_commit(11, 32'h0000100F);
    put(r_type(7'h00, 3'd7, 12, 2, 11));
    expect_commit(12, 32'h00001008);
    put(r_type(7'h00, 3'd1, 13, 7, 7));
    expect_commit(13, 32'h00078000);
    // x0 destination commits nothing
    put(i_type(3'd0, 0, 2, 12'h001, OP_IMM));
    put(i_type(3'd1, 14, 7, 12'h004, OP_IMM));
    expect_commit(14, 32'h000000F0);
  endtask

  task automatic load_mem_program();
    clear_program();
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(i);
    end
    put(u_type(OP_LUI, 1, 20'h12345));
    expect_commit(1, 32'h12345000);
    put(i_type(3'd0, 1, 1, 12'h678, OP_IMM));
    expect_commit(1, 32'h12345678);
    put(i_type(3'd0, 2, 0, 12'h040, OP_IMM));
    expect_commit(2, 32'h40);
    put(s_type(2, 1, 12'd0));
    put(i_type(3'd0, 3, 0, 12'hFFF, OP_IMM));
    expect_commit(3, 32'hFFFFFFFF);
    put(s_type(2, 3, 12'd8));
    put(i_type(3'd2, 4, 2, 12'd0, OP_LOAD));
    expect_commit(4, 32'h12345678);
    put(i_type(3'd2, 5, 2, 12'd8, OP_LOAD));
    expect_commit(5, 32'hFFFFFFFF);
    put(i_type(3'd2, 6, 2, 12'd4, OP_LOAD));
    expect_commit(6, fill_word(17));
    put(r_type(7'h00, 3'd0, 7, 4, 5));
    expect_commit(7, 32'h12345677);
    put(s_type(2, 7, 12'd12));
    put(i_type(3'd2, 8, 2, 12'd12, OP_LOAD));
    expect_commit(8, 32'h12345677);
  endtask

  task automatic check_mem_contents(input string name);
    check_value(name, "word 0x40", 32'h12345678, dmem[16]);
    check_value(name, "word 0x44", fill_word(17), dmem[17]);
    check_value(name, "word 0x48", 32'hFFFFFFFF, dmem[18]);
    check_value(name, "word 0x4c", 32'h12345677, dmem[19]);
  endtask

  task automatic test_alu_imm();
    load_alu_program();
    run_program("alu_imm", 1'b0);
  endtask

  task automatic test_branches();
    int rs1_tab [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    int rs2_tab [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    int f3_tab [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    clear_program();
    put(i_type(3'd0, 1, 0, 12'hFFF, OP_IMM));
    expect_commit(1, 32'hFFFFFFFF);
    put(i_type(3'd0, 2, 0, 12'h001, OP_IMM));
    expect_commit(2, 32'd1);
    put(i_type(3'd0, 3, 0, 12'h001, OP_IMM));
    expect_commit(3, 32'd1);
    for (int k = 0; k < 12; k++) begin
      // even entries take the branch over the x20 marker
      put(b_type(3'(f3_tab[k]), 5'(rs1_tab[k]), 5'(rs2_tab[k]), 13'd8));
      put(i_type(3'd0, 20, 0, 12'(100 + k), OP_IMM));
      put(i_type(3'd0, 21, 0, 12'(200 + k), OP_IMM));
      if (k % 2 == 1) begin
        expect_commit(20, 100 + k);
      end
      expect_commit(21, 200 + k);
    end
    run_program("branches", 1'b0);
  endtask

  task automatic test_jumps();
    clear_program();
    put(j_type(5, 21'd12));
    expect_commit(5, 32'd4);
    put(i_type(3'd0, 6, 0, 12'd1, OP_IMM));
    put(i_type(3'd0, 6, 0, 12'd2, OP_IMM));
    put(i_type(3'd0, 7, 0, 12'd41, OP_IMM));
    expect_commit(7, 32'd41);
    put(i_type(3'd0, 8, 0, 12'd35, OP_IMM));
    expect_commit(8, 32'd35);
    // 35 - 2 = 33 and clearing the low bit gives 32
    put(i_type(3'd0, 9, 8, 12'hFFE, OP_JALR));
    expect_commit(9, 32'd24);
    put(i_type(3'd0, 10, 0, 12'd7, OP_IMM));
    put(i_type(3'd0, 10, 0, 12'd8, OP_IMM));
    // auipc at the jalr target sees the aligned pc
    put(u_type(OP_AUIPC, 11, 20'h00000));
    expect_commit(11, 32'd32);
    put(j_type(0, 21'd8));
    put(i_type(3'd0, 12, 0, 12'd1, OP_IMM));
    put(i_type(3'd0, 12, 0, 12'd3, OP_IMM));
    expect_commit(12, 32'd3);
    run_program("jumps", 1'b0);
  endtask

  task automatic test_load_store();
    load_mem_program();
    run_program("load_store", 1'b0);
    check_mem_contents("load_store");
  endtask

  task automatic test_backpressure();
    load_alu_program();
    run_program("backpressure_alu", 1'b1);
    load_mem_program();
    run_program("backpressure_mem", 1'b1);
    check_mem_contents("backpressure_mem");
  endtask

  task automatic test_reset();
    load_alu_program();
    start_run("reset_midrun", 1'b0);
    while (got_n < 4) @(negedge clock);
    run_program("reset_rerun", 1'b0);
  endtask

  initial begin
    reset = 1'b1;
    clear_program();
    test_alu_imm();
    test_branches();
    test_jumps();
    test_load_store();
    test_backpressure();
    test_reset();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/exu_pkg.sv
verilog/exu_ifs.sv
verilog/alu.sv
verilog/load_store_unit.sv
verilog/inst_decode.sv
verilog/execute_stage.sv
verilog/writeback_regfile.sv
verilog/exu_top.sv
sim/tb_exu_top.sv

/* verilog/alu.sv */
module alu (
  input  logic [31:0]      a,
  input  logic [31:0]      b,
  input  exu_pkg::alu_op_e op,
  input  exu_pkg::branch_e branch,
  output logic [31:0]      result,
  output logic             cond_true
);

  logic [32:0] diff;
  logic        eq;
  logic        lt_u;
  logic        lt_s;

  // one subtract serves sub, slt, sltu and all compares
  assign diff = {1'b0, a} - {1'b0, b};
  assign eq = (diff[31:0] == 32'd0);
  assign lt_u = diff[32];
  assign lt_s = (a[31] ^ b[31]) ? a[31] : diff[31];

  always_comb begin
    case (op)
      exu_pkg::alu_sub:    result = diff[31:0];
      exu_pkg::alu_sll:    result = a << b[4:0];
      exu_pkg::alu_slt:    result = {31'd0, lt_s};
      exu_pkg::alu_sltu:   result = {31'd0, lt_u};
      exu_pkg::alu_xor:    result = a ^ b;
      exu_pkg::alu_srl:    result = a >> b[4:0];
      exu_pkg::alu_sra:    result = $signed(a) >>> b[4:0];
      exu_pkg::alu_or:     result = a | b;
      exu_pkg::alu_and:    result = a & b;
      exu_pkg::alu_pass_b: result = b;
      default:             result = a + b;
    endcase
  end

  always_comb begin
    case (branch)
      exu_pkg::br_beq:  cond_true = eq;
      exu_pkg::br_bne:  cond_true = !eq;
      exu_pkg::br_blt:  cond_true = lt_s;
      exu_pkg::br_bge:  cond_true = !lt_s;
      exu_pkg::br_bltu: cond_true = lt_u;
      exu_pkg::br_bgeu: cond_true = !lt_u;
      exu_pkg::br_jal, exu_pkg::br_jalr: cond_true = 1'b1;
      default:          cond_true = 1'b0;
    endcase
  end

endmodule

/* verilog/execute_stage.sv */
module execute_stage (
  input  logic        clock,
  input  logic        reset,
  uop_if.sink         uop_in,
  result_if.source    result_out,
  mem_if.source       mem,
  output logic        redirect_valid,
  output logic [31:0] redirect_pc,
  output logic [4:0]  busy_rd,
  output logic        busy_valid
);

  logic          ex_valid;
  logic          fresh;
  exu_pkg::uop_t ex_uop;
  logic          accept;
  logic          is_mem;
  logic          is_jump;
  logic          op_done;
  logic          finish;
  logic [31:0]   alu_a;
  logic [31:0]   alu_b;
  logic [31:0]   alu_result;
  logic          cond_true;
  logic [31:0]   link;
  logic [31:0]   target;
  logic          lsu_done;
  logic [31:0]   lsu_rdata;

  assign accept = uop_in.valid && uop_in.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
      fresh    <= 1'b0;
    end else begin
      // first cycle of a held op, used to start the lsu once
      fresh <= accept;
      if (accept) begin
        ex_valid <= 1'b1;
      end else if (finish) begin
        ex_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      ex_uop <= uop_in.uop;
    end
  end

  assign alu_a = ex_uop.src_a_pc ? ex_uop.pc : ex_uop.rs1_val;
  assign alu_b = ex_uop.src_b_imm ? ex_uop.imm : ex_uop.rs2_val;

  alu u_alu (
    .a         (alu_a),
    .b         (alu_b),
    .op        (ex_uop.alu_op),
    .branch    (ex_uop.branch),
    .result    (alu_result),
    .cond_true (cond_true)
  );

  assign is_mem = (ex_uop.mem != exu_pkg::mem_none);

  load_store_unit u_lsu (
    .clock    (clock),
    .reset    (reset),
    .start    (ex_valid && fresh && is_mem),
    .is_store (ex_uop.mem == exu_pkg::mem_store),
    .addr     (alu_result),
    .wdata    (ex_uop.rs2_val),
    .done     (lsu_done),
    .rdata    (lsu_rdata),
    .mem      (mem)
  );

  // lsu done is stale in the start cycle
  assign op_done = is_mem ? (lsu_done && !fresh) : 1'b1;

  assign result_out.valid = ex_valid && op_done && (ex_uop.rd != 5'd0);
  assign finish = ex_valid && op_done && ((ex_uop.rd == 5'd0) || result_out.ready);

  assign is_jump = (ex_uop.branch == exu_pkg::br_jal) || (ex_uop.branch == exu_pkg::br_jalr);
  assign link = ex_uop.pc + 32'd4;
  assign target = ((ex_uop.branch == exu_pkg::br_jalr) ? ex_uop.rs1_val : ex_uop.pc) +
                  ex_uop.imm;

  assign result_out.rd = ex_uop.rd;
  always_comb begin
    if (ex_uop.mem == exu_pkg::mem_load) begin
      result_out.data = lsu_rdata;
    end else if (is_jump) begin
      result_out.data = link;
    end else begin
      result_out.data = alu_result;
    end
  end

  // predict not taken, so any taken transfer redirects
  assign redirect_valid = finish && cond_true;
  assign redirect_pc = {target[31:1], 1'b0};

  assign uop_in.ready = !ex_valid || (finish && !redirect_valid);

  assign busy_rd = ex_uop.rd;
  assign busy_valid = ex_valid && (ex_uop.rd != 5'd0);

  assert property (@(posedge clock) disable iff (reset)
    redirect_valid |=> !redirect_valid);

endmodule

/* verilog/exu_ifs.sv */
interface uop_if;
  logic          valid;
  logic          ready;
  exu_pkg::uop_t uop;
  modport source (output valid, output uop, input ready);
  modport sink (input valid, input uop, output ready);
endinterface

interface result_if;
  logic        valid;
  logic        ready;
  logic [4:0]  rd;
  logic [31:0] data;
  modport source (output valid, output rd, output data, input ready);
  modport sink (input valid, input rd, input data, output ready);
endinterface

// combinational register read
interface reg_read_if;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  modport requester (output rs1, output rs2, input rs1_val, input rs2_val);
  modport responder (input rs1, input rs2, output rs1_val, output rs2_val);
endinterface

interface mem_if;
  logic        req_valid;
  logic        req_ready;
  logic        write;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        resp_valid;
  logic [31:0] rdata;
  modport source (output req_valid, output write, output addr, output wdata,
                  input req_ready, input resp_valid, input rdata);
endinterface

/* verilog/exu_pkg.sv */
package exu_pkg;

  localparam int DEFAULT_NUM_REGS = 32;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // control transfer kind, br_none for plain ops
  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_jal,
    br_jalr
  } branch_e;

  typedef enum logic [1:0] {
    mem_none,
    mem_load,
    mem_store
  } mem_e;

  typedef enum logic [1:0] {
    lsu_idle,
    lsu_request,
    lsu_wait_resp
  } lsu_state_e;

  typedef struct packed {
    alu_op_e     alu_op;
    logic        src_a_pc;
    logic        src_b_imm;
    branch_e     branch;
    mem_e        mem;
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
  } uop_t;

endpackage

/* verilog/exu_top.sv */
module exu_top #(
  parameter int num_regs = exu_pkg::DEFAULT_NUM_REGS
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [31:0] in_pc,
  input  logic [31:0] in_inst,
  output logic        redirect_valid,
  output logic [31:0] redirect_pc,
  output logic        mem_req_valid,
  input  logic        mem_req_ready,
  output logic        mem_write,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  input  logic        mem_resp_valid,
  input  logic [31:0] mem_rdata,
  output logic        wb_valid,
  input  logic        wb_ready,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data
);

  uop_if      uop_link ();
  result_if   result_link ();
  reg_read_if reg_link ();
  mem_if      mem_link ();

  logic [4:0] busy_rd;
  logic       busy_valid;

  inst_decode #(.num_regs(num_regs)) u_decode (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_pc      (in_pc),
    .in_inst    (in_inst),
    .flush      (redirect_valid),
    .busy_rd    (busy_rd),
    .busy_valid (busy_valid),
    .rd_port    (reg_link),
    .uop_out    (uop_link)
  );

  execute_stage u_execute (
    .clock          (clock),
    .reset          (reset),
    .uop_in         (uop_link),
    .result_out     (result_link),
    .mem            (mem_link),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .busy_rd        (busy_rd),
    .busy_valid     (busy_valid)
  );

  writeback_regfile #(.num_regs(num_regs)) u_writeback (
    .clock     (clock),
    .reset     (reset),
    .result_in (result_link),
    .rd_port   (reg_link),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  assign mem_req_valid = mem_link.req_valid;
  assign mem_write = mem_link.write;
  assign mem_addr = mem_link.addr;
  assign mem_wdata = mem_link.wdata;
  assign mem_link.req_ready = mem_req_ready;
  assign mem_link.resp_valid = mem_resp_valid;
  assign mem_link.rdata = mem_rdata;

endmodule

/* verilog/inst_decode.sv */
module inst_decode #(
  parameter int num_regs = 32
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [31:0] in_pc,
  input  logic [31:0] in_inst,
  input  logic        flush,
  input  logic [4:0]  busy_rd,
  input  logic        busy_valid,
  reg_read_if.requester rd_port,
  uop_if.source       uop_out
);

  logic        dec_valid;
  logic [31:0] pc_q;
  logic [31:0] inst_q;
  logic [2:0]  f3;
  logic [4:0]  rd_field;
  logic        writes_rd;
  logic        stall;
  exu_pkg::uop_t uop;

  function automatic exu_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic f7b5,
                                               input logic is_reg);
    case (funct3)
      3'b000:  alu_sel = (is_reg && f7b5) ? exu_pkg::alu_sub : exu_pkg::alu_add;
      3'b001:  alu_sel = exu_pkg::alu_sll;
      3'b010:  alu_sel = exu_pkg::alu_slt;
      3'b011:  alu_sel = exu_pkg::alu_sltu;
      3'b100:  alu_sel = exu_pkg::alu_xor;
      3'b110:  alu_sel = exu_pkg::alu_or;
      3'b111:  alu_sel = exu_pkg::alu_and;
      default: alu_sel = f7b5 ? exu_pkg::alu_sra : exu_pkg::alu_srl;
    endcase
  endfunction

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      dec_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      dec_valid <= 1'b1;
    end else if (uop_out.valid && uop_out.ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      pc_q   <= in_pc;
      inst_q <= in_inst;
    end
  end

  assign f3 = inst_q[14:12];
  assign rd_field = inst_q[11:7];
  assign rd_port.rs1 = inst_q[19:15];
  assign rd_port.rs2 = inst_q[24:20];

  always_comb begin
    uop = '0;
    writes_rd = 1'b0;
    uop.pc = pc_q;
    uop.rs1_val = rd_port.rs1_val;
    uop.rs2_val = rd_port.rs2_val;
    uop.imm = {{20{inst_q[31]}}, inst_q[31:20]};
    case (inst_q[6:0])
      7'b0110111, 7'b0010111: begin
        uop.alu_op = (inst_q[5]) ? exu_pkg::alu_pass_b : exu_pkg::alu_add;
        uop.src_a_pc = ~inst_q[5];
        uop.src_b_imm = 1'b1;
        uop.imm = {inst_q[31:12], 12'b0};
        writes_rd = 1'b1;
      end
      7'b1101111: begin
        uop.branch = exu_pkg::br_jal;
        uop.imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                   inst_q[30:21], 1'b0};
        writes_rd = 1'b1;
      end
      7'b1100111: begin
        uop.branch = exu_pkg::br_jalr;
        writes_rd = 1'b1;
      end
      7'b1100011: begin
        uop.alu_op = exu_pkg::alu_sub;
        uop.imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                   inst_q[11:8], 1'b0};
        case (f3)
          3'b000:  uop.branch = exu_pkg::br_beq;
          3'b001:  uop.branch = exu_pkg::br_bne;
          3'b100:  uop.branch = exu_pkg::br_blt;
          3'b101:  uop.branch = exu_pkg::br_bge;
          3'b110:  uop.branch = exu_pkg::br_bltu;
          3'b111:  uop.branch = exu_pkg::br_bgeu;
          default: uop.branch = exu_pkg::br_none;
        endcase
      end
      7'b0000011, 7'b0100011: begin
        // word access only, address is rs1 + imm
        uop.alu_op = exu_pkg::alu_add;
        uop.src_b_imm = 1'b1;
        uop.mem = inst_q[5] ? exu_pkg::mem_store : exu_pkg::mem_load;
        if (inst_q[5]) begin
          uop.imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
        end
        writes_rd = ~inst_q[5];
      end
      7'b0010011, 7'b0110011: begin
        uop.alu_op = alu_sel(f3, inst_q[30], inst_q[5]);
        uop.src_b_imm = ~inst_q[5];
        writes_rd = 1'b1;
      end
      default: ;
    endcase
    // RV32E has no registers above num_regs
    uop.rd = (writes_rd && rd_field < num_regs) ? rd_field : 5'd0;
  end

  // hold back while execute still owns a source register
  assign stall = busy_valid &&
                 ((rd_port.rs1 != 5'd0 && rd_port.rs1 == busy_rd) ||
                  (rd_port.rs2 != 5'd0 && rd_port.rs2 == busy_rd));

  assign uop_out.valid = dec_valid && !stall;
  assign uop_out.uop = uop;
  assign in_ready = !dec_valid || (uop_out.valid && uop_out.ready);

  // execute keeps its ready low while it redirects
  assert property (@(posedge clock) disable iff (reset)
    flush |-> !(uop_out.valid && uop_out.ready));

endmodule

/* verilog/load_store_unit.sv */
module load_store_unit (
  input  logic        clock,
  input  logic        reset,
  input  logic        start,
  input  logic        is_store,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output logic        done,
  output logic [31:0] rdata,
  mem_if.source       mem
);

  exu_pkg::lsu_state_e state;
  logic                store_q;
  logic [31:0]         addr_q;
  logic [31:0]         wdata_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= exu_pkg::lsu_idle;
      done  <= 1'b0;
    end else begin
      case (state)
        exu_pkg::lsu_idle: begin
          if (start) begin
            state <= exu_pkg::lsu_request;
            done  <= 1'b0;
          end
        end
        exu_pkg::lsu_request: begin
          if (mem.req_ready) begin
            // stores finish as soon as the request is taken
            state <= store_q ? exu_pkg::lsu_idle : exu_pkg::lsu_wait_resp;
            done  <= store_q;
          end
        end
        exu_pkg::lsu_wait_resp: begin
          if (mem.resp_valid) begin
            state <= exu_pkg::lsu_idle;
            done  <= 1'b1;
          end
        end
        default: state <= exu_pkg::lsu_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == exu_pkg::lsu_idle && start) begin
      store_q <= is_store;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (state == exu_pkg::lsu_wait_resp && mem.resp_valid) begin
      rdata <= mem.rdata;
    end
  end

  assign mem.req_valid = (state == exu_pkg::lsu_request);
  assign mem.write = store_q;
  assign mem.addr = addr_q;
  assign mem.wdata = wdata_q;

  // the memory answers only loads that were issued
  assert property (@(posedge clock) disable iff (reset)
    (state == exu_pkg::lsu_idle) |-> !mem.resp_valid);

endmodule

/* verilog/writeback_regfile.sv */
module writeback_regfile #(
  parameter int num_regs = 32
) (
  input  logic          clock,
  input  logic          reset,
  result_if.sink        result_in,
  reg_read_if.responder rd_port,
  output logic          wb_valid,
  input  logic          wb_ready,
  output logic [4:0]    wb_rd,
  output logic [31:0]   wb_data
);

  logic [31:0] regs [num_regs];
  logic        xfer;

  assign result_in.ready = !wb_valid || wb_ready;
  assign xfer = result_in.valid && result_in.ready;

  // x0 is never stored
  always_ff @(posedge clock) begin
    if (xfer && result_in.rd != 5'd0 && result_in.rd < num_regs) begin
      regs[result_in.rd] <= result_in.data;
    end
  end

  assign rd_port.rs1_val = (rd_port.rs1 != 5'd0 && rd_port.rs1 < num_regs) ?
                           regs[rd_port.rs1] : 32'd0;
  assign rd_port.rs2_val = (rd_port.rs2 != 5'd0 && rd_port.rs2 < num_regs) ?
                           regs[rd_port.rs2] : 32'd0;

  // one entry commit register
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (xfer) begin
      wb_valid <= 1'b1;
    end else if (wb_ready) begin
      wb_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (xfer) begin
      wb_rd   <= result_in.rd;
      wb_data <= result_in.data;
    end
  end

endmodule
